/* design/cache_cfg_pkg.sv */
// ----------------------------------------------------------------------
// Cache geometry: address, word, line and tag widths
// and the types built from them
// ----------------------------------------------------------------------

package cache_cfg_pkg;

  parameter int addr_width     = 32;
  parameter int word_width     = 32;
  parameter int words_per_line = 4;
  parameter int line_width     = word_width * words_per_line;  // 128
  parameter int offset_width   = $clog2(line_width / 8);       // Byte offset in a line
  parameter int word_sel_width = $clog2(words_per_line);

  // Every address bit above the line offset is kept as tag
  parameter int tag_width      = addr_width - offset_width;

  typedef logic [addr_width-1:0]     addr_t;
  typedef logic [word_width-1:0]     word_t;
  typedef logic [line_width-1:0]     line_t;
  typedef logic [tag_width-1:0]      tag_t;
  typedef logic [word_sel_width-1:0] word_sel_t;

endpackage

/* design/cache_types_pkg.sv */
// ----------------------------------------------------------------------
// Request opcodes, controller states and memory opcodes
// ----------------------------------------------------------------------

package cache_types_pkg;

  // Processor request kind, code 3 is treated as read
  typedef enum logic [1:0] {
    op_read  = 2'd0,
    op_write = 2'd1,
    op_init  = 2'd2
  } cache_op_e;

  typedef enum logic [3:0] {
    st_idle           = 4'd0,
    st_tag_check      = 4'd1,
    st_init_access    = 4'd2,
    st_read_access    = 4'd3,
    st_write_access   = 4'd4,
    st_evict_request  = 4'd5,
    st_evict_wait     = 4'd6,
    st_refill_request = 4'd7,
    st_refill_wait    = 4'd8,
    st_refill_update  = 4'd9,
    st_resp_wait      = 4'd10
  } ctrl_state_e;

  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_op_e;

endpackage

/* design/cache_ifc.sv */
// ----------------------------------------------------------------------
// Decoded request bundle and way-array control/status bundle
// ----------------------------------------------------------------------

`timescale 1ns/100ps

interface cache_req_if #(parameter int num_sets = 8);

  localparam int index_width = $clog2(num_sets);

  logic                          req_start;  // One cycle after acceptance
  cache_types_pkg::cache_op_e    op;
  cache_cfg_pkg::tag_t           tag;
  logic [index_width-1:0]        index;
  cache_cfg_pkg::word_sel_t      word_sel;
  cache_cfg_pkg::word_t          wdata;

  modport source (output req_start, op, tag, index, word_sel, wdata);
  modport sink   (input  req_start, op, tag, index, word_sel, wdata);

endinterface

interface way_if;

  // Controls from the FSM
  logic                  init_en;
  logic                  word_write_en;
  logic                  refill_en;
  logic                  lru_touch;

  // Status from the arrays
  logic                  hit;
  logic                  hit_way;
  logic                  victim_dirty;   // LRU way valid and dirty
  cache_cfg_pkg::tag_t   victim_tag;
  cache_cfg_pkg::line_t  victim_line;
  cache_cfg_pkg::line_t  hit_line;

  modport ctrl   (output init_en, word_write_en, refill_en, lru_touch,
                  input  hit, victim_dirty);
  modport store  (input  init_en, word_write_en, refill_en, lru_touch,
                  output hit, hit_way, victim_dirty, victim_tag, victim_line, hit_line);
  modport result (input  hit, hit_line, victim_tag, victim_line);

endinterface

/* design/cache_req_decode.sv */
// ----------------------------------------------------------------------
// Processor request acceptance, address split and field latch
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module cache_req_decode #(
  parameter int num_sets = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cachereq_val,
  input  logic [1:0]            cachereq_type,
  input  cache_cfg_pkg::addr_t  cachereq_addr,
  input  cache_cfg_pkg::word_t  cachereq_data,
  input  logic                  cachereq_rdy,
  cache_req_if.source           req
);

  localparam int index_width = $clog2(num_sets);
  localparam int offset_width = cache_cfg_pkg::offset_width;

  logic                        accept;
  cache_types_pkg::cache_op_e  op_in;

  assign accept = cachereq_val && cachereq_rdy;

  always_comb begin
    case (cachereq_type)
      2'd1:    op_in = cache_types_pkg::op_write;
      2'd2:    op_in = cache_types_pkg::op_init;
      default: op_in = cache_types_pkg::op_read;  // 0 and 3
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      req.req_start <= 1'b0;
    end else begin
      req.req_start <= accept;
    end
  end

  // Fields held until the next accepted request
  always_ff @(posedge clk) begin
    if (accept) begin
      req.op       <= op_in;
      req.tag      <= cachereq_addr[cache_cfg_pkg::addr_width-1:offset_width];
      req.index    <= cachereq_addr[offset_width +: index_width];
      req.word_sel <= cachereq_addr[offset_width-1:2];  // Word within the line
      req.wdata    <= cachereq_data;
    end
  end

endmodule

/* design/cache_ctrl_fsm.sv */
// ----------------------------------------------------------------------
// Cache controller FSM: tag check, access, eviction, refill, response
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module cache_ctrl_fsm (
  input  logic  clk,
  input  logic  reset,
  input  logic  memreq_rdy,
  input  logic  memresp_val,
  input  logic  cacheresp_rdy,
  output logic  cachereq_rdy,
  output logic  cacheresp_val,
  output logic  memreq_val,
  output logic  memresp_rdy,
  output logic  resp_capture,
  output logic  evict_select,
  cache_req_if.sink  req,
  way_if.ctrl        ways
);

  cache_types_pkg::ctrl_state_e state_q, state_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= cache_types_pkg::st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      cache_types_pkg::st_idle:
        if (req.req_start) state_d = cache_types_pkg::st_tag_check;
      cache_types_pkg::st_tag_check: begin
        if (req.op == cache_types_pkg::op_init)
          state_d = cache_types_pkg::st_init_access;
        else if (ways.hit && req.op == cache_types_pkg::op_write)
          state_d = cache_types_pkg::st_write_access;
        else if (ways.hit)
          state_d = cache_types_pkg::st_read_access;
        else if (ways.victim_dirty)
          state_d = cache_types_pkg::st_evict_request;
        else
          state_d = cache_types_pkg::st_refill_request;
      end
      cache_types_pkg::st_init_access,
      cache_types_pkg::st_read_access,
      cache_types_pkg::st_write_access:
        state_d = cache_types_pkg::st_resp_wait;
      cache_types_pkg::st_evict_request:
        if (memreq_rdy) state_d = cache_types_pkg::st_evict_wait;
      cache_types_pkg::st_evict_wait:
        if (memresp_val) state_d = cache_types_pkg::st_refill_request;  // Write-back acked
      cache_types_pkg::st_refill_request:
        if (memreq_rdy) state_d = cache_types_pkg::st_refill_wait;
      cache_types_pkg::st_refill_wait:
        if (memresp_val) state_d = cache_types_pkg::st_refill_update;
      cache_types_pkg::st_refill_update:
        state_d = (req.op == cache_types_pkg::op_write) ? cache_types_pkg::st_write_access
                                                        : cache_types_pkg::st_read_access;
      cache_types_pkg::st_resp_wait:
        if (cacheresp_rdy) state_d = cache_types_pkg::st_idle;
      default:
        state_d = cache_types_pkg::st_idle;
    endcase
  end

  // ----------------------------------------------------------------------
  // Outputs decoded from state
  // ----------------------------------------------------------------------

  // Closed while the latched request waits for its tag check
  assign cachereq_rdy  = (state_q == cache_types_pkg::st_idle) && !req.req_start;
  assign cacheresp_val = (state_q == cache_types_pkg::st_resp_wait);
  assign memreq_val    = (state_q == cache_types_pkg::st_evict_request) ||
                         (state_q == cache_types_pkg::st_refill_request);
  assign memresp_rdy   = (state_q == cache_types_pkg::st_evict_wait) ||
                         (state_q == cache_types_pkg::st_refill_wait);
  assign evict_select  = (state_q == cache_types_pkg::st_evict_request) ||
                         (state_q == cache_types_pkg::st_evict_wait);

  assign resp_capture  = (state_q == cache_types_pkg::st_init_access) ||
                         (state_q == cache_types_pkg::st_read_access) ||
                         (state_q == cache_types_pkg::st_write_access);

  assign ways.init_en       = (state_q == cache_types_pkg::st_init_access);
  assign ways.word_write_en = (state_q == cache_types_pkg::st_init_access) ||
                              (state_q == cache_types_pkg::st_write_access);
  assign ways.refill_en     = (state_q == cache_types_pkg::st_refill_update);
  assign ways.lru_touch     = resp_capture;  // Every access marks its way used

  // Memory and processor sides are never offered together
  assert property (@(posedge clk) disable iff (reset) !(memreq_val && cacheresp_val));

  // A write-back only ever carries a dirty victim
  assert property (@(posedge clk) disable iff (reset)
    memreq_val && evict_select |-> ways.victim_dirty);

  assert property (@(posedge clk) disable iff (reset)
    !$isunknown(state_q) && state_q <= cache_types_pkg::st_resp_wait);

endmodule

/* design/cache_way_arrays.sv */
// ----------------------------------------------------------------------
// Two-way tag, valid, dirty and line storage with per-set LRU bit
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module cache_way_arrays #(
  parameter int num_sets = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  cache_req_if.sink             req,
  way_if.store                  ways,
  input  cache_cfg_pkg::line_t  memresp_data
);

  localparam int index_width = $clog2(num_sets);
  localparam int ww = cache_cfg_pkg::word_width;

  cache_cfg_pkg::tag_t   tag_mem  [2][num_sets];
  cache_cfg_pkg::line_t  data_mem [2][num_sets];
  logic [num_sets-1:0]   valid_q  [2];
  logic [num_sets-1:0]   dirty_q  [2];
  logic [num_sets-1:0]   lru_q;              // Names the victim way per set

  logic [index_width-1:0]  idx;
  logic [1:0]              match;
  logic                    victim;
  logic                    wr_way;
  logic [cache_cfg_pkg::words_per_line-1:0] word_en;
  cache_cfg_pkg::line_t    write_line;
  cache_cfg_pkg::line_t    refill_buf;

  assign idx = req.index;

  // Tag check across both ways
  assign match[0] = valid_q[0][idx] && (tag_mem[0][idx] == req.tag);
  assign match[1] = valid_q[1][idx] && (tag_mem[1][idx] == req.tag);

  assign ways.hit      = |match;
  assign ways.hit_way  = match[1];
  assign ways.hit_line = data_mem[ways.hit_way][idx];

  assign victim            = lru_q[idx];
  assign ways.victim_dirty = valid_q[victim][idx] && dirty_q[victim][idx];
  assign ways.victim_tag   = tag_mem[victim][idx];
  assign ways.victim_line  = data_mem[victim][idx];

  assign wr_way  = ways.init_en ? 1'b0 : ways.hit_way;  // Init always lands in way 0
  assign word_en = 4'b0001 << req.word_sel;

  always_comb begin
    write_line = data_mem[wr_way][idx];
    for (int w = 0; w < cache_cfg_pkg::words_per_line; w++) begin
      if (word_en[w]) write_line[w*ww +: ww] = req.wdata;
    end
  end

  // Sampled every cycle, so it holds the line from the memresp handshake
  always_ff @(posedge clk) begin
    refill_buf <= memresp_data;
  end

  always_ff @(posedge clk) begin
    if (ways.refill_en) begin
      tag_mem[victim][idx]  <= req.tag;
      data_mem[victim][idx] <= refill_buf;
    end else if (ways.word_write_en) begin
      data_mem[wr_way][idx] <= write_line;
      if (ways.init_en) tag_mem[0][idx] <= req.tag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q[0] <= '0;
      valid_q[1] <= '0;
      dirty_q[0] <= '0;
      dirty_q[1] <= '0;
      lru_q      <= '0;
    end else begin
      if (ways.refill_en) begin
        valid_q[victim][idx] <= 1'b1;
        dirty_q[victim][idx] <= 1'b0;         // Refilled line is clean
      end else if (ways.word_write_en) begin
        valid_q[wr_way][idx] <= 1'b1;
        dirty_q[wr_way][idx] <= !ways.init_en;
      end
      if (ways.lru_touch) lru_q[idx] <= ~wr_way;  // Other way becomes victim
    end
  end

  // Stores reach only a resident line or an init
  assert property (@(posedge clk) disable iff (reset)
    ways.word_write_en |-> ways.hit || ways.init_en);

endmodule

/* design/cache_resp_unit.sv */
// ----------------------------------------------------------------------
// Processor response register and memory request payload
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module cache_resp_unit (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       resp_capture,
  input  logic                       evict_select,
  cache_req_if.sink                  req,
  way_if.result                      ways,
  output logic [1:0]                 cacheresp_type,
  output cache_cfg_pkg::word_t       cacheresp_data,
  output logic                       cacheresp_hit,
  output cache_types_pkg::mem_op_e   memreq_type,
  output cache_cfg_pkg::addr_t       memreq_addr,
  output cache_cfg_pkg::line_t       memreq_data
);

  localparam int ww = cache_cfg_pkg::word_width;

  logic                   check_hit;  // Tag check result before any refill
  cache_cfg_pkg::word_t   read_word;
  cache_cfg_pkg::tag_t    line_tag;

  // Arrays are stable from req_start through tag check
  always_ff @(posedge clk) begin
    if (req.req_start) check_hit <= ways.hit;
  end

  assign read_word = ways.hit_line[req.word_sel*ww +: ww];

  always_ff @(posedge clk) begin
    if (reset) begin
      cacheresp_type <= 2'd0;
      cacheresp_hit  <= 1'b0;
      cacheresp_data <= '0;
    end else if (resp_capture) begin
      cacheresp_type <= req.op;
      cacheresp_hit  <= check_hit && (req.op != cache_types_pkg::op_init);
      cacheresp_data <= (req.op == cache_types_pkg::op_read) ? read_word : '0;
    end
  end

  // ----------------------------------------------------------------------
  // Memory request, write-back of the victim or refill of the request line
  // ----------------------------------------------------------------------

  assign line_tag    = evict_select ? ways.victim_tag : req.tag;
  assign memreq_addr = {line_tag, {cache_cfg_pkg::offset_width{1'b0}}};
  assign memreq_type = evict_select ? cache_types_pkg::mem_write : cache_types_pkg::mem_read;
  assign memreq_data = ways.victim_line;

endmodule

/* design/blocking_cache.sv */
// ----------------------------------------------------------------------
// Two-way blocking write-back cache, top level
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module blocking_cache #(
  parameter int num_sets = 8
) (
  input  logic                      clk,
  input  logic                      reset,
  // Processor side
  input  logic                      cachereq_val,
  output logic                      cachereq_rdy,
  input  logic [1:0]                cachereq_type,
  input  cache_cfg_pkg::addr_t      cachereq_addr,
  input  cache_cfg_pkg::word_t      cachereq_data,
  output logic                      cacheresp_val,
  input  logic                      cacheresp_rdy,
  output logic [1:0]                cacheresp_type,
  output cache_cfg_pkg::word_t      cacheresp_data,
  output logic                      cacheresp_hit,
  // Memory side, one line per transfer
  output logic                      memreq_val,
  input  logic                      memreq_rdy,
  output cache_types_pkg::mem_op_e  memreq_type,
  output cache_cfg_pkg::addr_t      memreq_addr,
  output cache_cfg_pkg::line_t      memreq_data,
  input  logic                      memresp_val,
  output logic                      memresp_rdy,
  input  cache_cfg_pkg::line_t      memresp_data
);

  logic resp_capture;
  logic evict_select;

  cache_req_if #(.num_sets(num_sets)) req_bus ();
  way_if                               way_bus ();

  cache_req_decode #(.num_sets(num_sets)) decode_i (
    .clk, .reset, .cachereq_val, .cachereq_type, .cachereq_addr, .cachereq_data,
    .cachereq_rdy, .req(req_bus.source)
  );

  cache_ctrl_fsm ctrl_i (
    .clk, .reset, .memreq_rdy, .memresp_val, .cacheresp_rdy,
    .cachereq_rdy, .cacheresp_val, .memreq_val, .memresp_rdy,
    .resp_capture, .evict_select, .req(req_bus.sink), .ways(way_bus.ctrl)
  );

  cache_way_arrays #(.num_sets(num_sets)) ways_i (
    .clk, .reset, .req(req_bus.sink), .ways(way_bus.store), .memresp_data
  );

  cache_resp_unit resp_i (
    .clk, .reset, .resp_capture, .evict_select, .req(req_bus.sink),
    .ways(way_bus.result), .cacheresp_type, .cacheresp_data, .cacheresp_hit,
    .memreq_type, .memreq_addr, .memreq_data
  );

endmodule

/* tests/tb_mem_model.sv */
// ----------------------------------------------------------------------
// Line-wide memory model with random ready and response delays
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module tb_mem_model (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      memreq_val,
  output logic                      memreq_rdy,
  input  cache_types_pkg::mem_op_e  memreq_type,
  input  cache_cfg_pkg::addr_t      memreq_addr,
  input  cache_cfg_pkg::line_t      memreq_data,
  output logic                      memresp_val,
  input  logic                      memresp_rdy,
  output cache_cfg_pkg::line_t      memresp_data
);

  cache_cfg_pkg::line_t lines [cache_cfg_pkg::addr_t];  // Lines written back so far
  cache_cfg_pkg::line_t pending;
  logic                 busy;
  logic                 resp_taken;
  int                   delay;

  // Untouched lines read back a pattern of their word addresses
  function automatic cache_cfg_pkg::line_t line_at(input cache_cfg_pkg::addr_t addr);
    cache_cfg_pkg::line_t line;
    cache_cfg_pkg::addr_t word_addr;
    if (lines.exists(addr)) return lines[addr];
    for (int w = 0; w < 4; w++) begin
      word_addr = addr + 4 * w;
      line[w*32 +: 32] = {word_addr[15:0], word_addr[31:16]} ^ 32'h6b3d_90c5;
    end
    return line;
  endfunction

  initial begin
    memreq_rdy   = 1'b0;
    memresp_val  = 1'b0;
    memresp_data = '0;
    busy         = 1'b0;
    resp_taken   = 1'b0;
    delay        = 0;
    forever begin
      @(negedge clk);
      if (reset) begin
        memreq_rdy  = 1'b0;
        memresp_val = 1'b0;
        busy        = 1'b0;
        resp_taken  = 1'b0;
      end else begin
        if (resp_taken) begin  // Response went out at the last rising edge
          memresp_val = 1'b0;
          busy        = 1'b0;
        end
        if (busy && !memresp_val) begin
          if (delay == 0) begin
            memresp_val  = 1'b1;
            memresp_data = pending;
          end else begin
            delay--;
          end
        end
        memreq_rdy = !busy && ($urandom_range(3) != 0);
        if (memreq_val && memreq_rdy) begin  // Taken at the next rising edge
          busy  = 1'b1;
          delay = $urandom_range(4);
          if (memreq_type == cache_types_pkg::mem_write) lines[memreq_addr] = memreq_data;
          pending = line_at(memreq_addr);
        end
        resp_taken = memresp_val && memresp_rdy;
      end
    end
  end

endmodule

/* tests/tb_blocking_cache.sv */
// ----------------------------------------------------------------------
// Blocking cache testbench: stimulus, reference models and checks
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module tb_blocking_cache;

  localparam int num_sets     = 8;
  localparam int index_width  = $clog2(num_sets);
  localparam int num_lines    = 24;
  localparam int num_requests = 300;
  localparam int max_cycles   = num_requests * 60;

  logic                      clk;
  logic                      reset;
  logic                      cachereq_val;
  logic                      cachereq_rdy;
  logic [1:0]                cachereq_type;
  cache_cfg_pkg::addr_t      cachereq_addr;
  cache_cfg_pkg::word_t      cachereq_data;
  logic                      cacheresp_val;
  logic                      cacheresp_rdy;
  logic [1:0]                cacheresp_type;
  cache_cfg_pkg::word_t      cacheresp_data;
  logic                      cacheresp_hit;
  logic                      memreq_val;
  logic                      memreq_rdy;
  cache_types_pkg::mem_op_e  memreq_type;
  cache_cfg_pkg::addr_t      memreq_addr;
  cache_cfg_pkg::line_t      memreq_data;
  logic                      memresp_val;
  logic                      memresp_rdy;
  cache_cfg_pkg::line_t      memresp_data;

  cache_cfg_pkg::word_t ref_store [cache_cfg_pkg::addr_t];  // Last value per word address
  cache_cfg_pkg::tag_t  model_tag [num_sets][2];
  logic [num_sets-1:0][1:0] model_valid;
  logic [num_sets-1:0][1:0] model_dirty;
  logic [num_sets-1:0]  model_lru;                  // Victim way per set
  int                   wb_due;                     // Write-backs predicted so far
  int                   wb_done;                    // Write-backs seen at memory
  cache_cfg_pkg::addr_t wb_addr;

  blocking_cache #(.num_sets(num_sets)) dut_i (.*);
  tb_mem_model mem_i (.*);

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "simulation stopped on the first failed check");
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
    report_failure($sformatf("mismatch %s: expected %0h, actual %0h", test, expected, actual));
  endtask

  // Same pattern the memory model returns for untouched lines
  function automatic cache_cfg_pkg::word_t default_word(input cache_cfg_pkg::addr_t addr);
    return {addr[15:0], addr[31:16]} ^ 32'h6b3d_90c5;
  endfunction

  function automatic cache_cfg_pkg::word_t expected_word(input cache_cfg_pkg::addr_t addr);
    if (ref_store.exists(addr)) return ref_store[addr];
    return default_word(addr);
  endfunction

  // Eight lines in each of sets 1, 3 and 5
  function automatic cache_cfg_pkg::addr_t line_base(input int i);
    return cache_cfg_pkg::addr_t'(((i / 3 + 1) << 12) | ((i % 3 * 2 + 1) << 4));
  endfunction

  // ----------------------------------------------------------------------
  // Two-way tag and LRU model, stepped as each request is issued
  // ----------------------------------------------------------------------

  task automatic predict_access(input cache_types_pkg::cache_op_e kind,
                                input cache_cfg_pkg::addr_t addr, output logic hit);
    cache_cfg_pkg::tag_t tag;
    int                  set;
    int                  way;
    tag = addr[31:4];
    set = int'(addr[4 +: index_width]);
    hit = 1'b0;
    if (kind == cache_types_pkg::op_init) begin
      model_tag[set][0]   = tag;             // Init always lands in way 0, clean
      model_valid[set][0] = 1'b1;
      model_dirty[set][0] = 1'b0;
      model_lru[set]      = 1'b1;
    end else begin
      way = int'(model_lru[set]);
      for (int w = 0; w < 2; w++) begin
        if (model_valid[set][w] && model_tag[set][w] == tag) begin
          hit = 1'b1;
          way = w;
        end
      end
      if (!hit) begin
        if (model_valid[set][way] && model_dirty[set][way]) begin
          wb_due++;
          wb_addr = {model_tag[set][way], 4'h0};
        end
        model_tag[set][way]   = tag;
        model_valid[set][way] = 1'b1;
        model_dirty[set][way] = 1'b0;
      end
      if (kind == cache_types_pkg::op_write) model_dirty[set][way] = 1'b1;
      model_lru[set] = (way == 0);
    end
  endtask

  // Starts and ends on a falling edge
  task automatic run_request(input cache_types_pkg::cache_op_e kind,
                             input cache_cfg_pkg::addr_t addr, input cache_cfg_pkg::word_t data);
    logic                 exp_hit;
    cache_cfg_pkg::word_t exp_data;
    int                   lat;
    logic                 mem_seen;
    logic [1:0]           held_type;
    cache_cfg_pkg::word_t held_data;
    logic                 held_hit;
    predict_access(kind, addr, exp_hit);
    exp_data = (kind == cache_types_pkg::op_read) ? expected_word(addr) : '0;
    if (kind != cache_types_pkg::op_read) ref_store[addr] = data;
    cachereq_val  = 1'b1;
    cachereq_type = kind;
    cachereq_addr = addr;
    cachereq_data = data;
    while (!cachereq_rdy) @(negedge clk);
    @(negedge clk);                      // Accepted at the rising edge just past
    cachereq_val = 1'b0;
    lat      = 0;
    mem_seen = 1'b0;
    while (!cacheresp_val) begin
      mem_seen = mem_seen || memreq_val;
      lat++;
      @(negedge clk);
    end
    if (exp_hit || kind == cache_types_pkg::op_init) begin
      assert (lat == 3) else report_mismatch("hit latency", 3, 32'(lat));
      assert (!mem_seen) else report_failure("memory request issued during a hit");
    end
    assert (cacheresp_type == kind)
      else report_mismatch("response type", 32'(kind), 32'(cacheresp_type));
    assert (cacheresp_hit == exp_hit)
      else report_mismatch("hit flag", 32'(exp_hit), 32'(cacheresp_hit));
    assert (cacheresp_data == exp_data) else report_mismatch("read data", exp_data, cacheresp_data);
    assert (wb_done == wb_due) else report_failure("predicted write-back never reached memory");
    held_type = cacheresp_type;
    held_data = cacheresp_data;
    held_hit  = cacheresp_hit;
    cacheresp_rdy = ($urandom_range(2) != 0);
    while (!cacheresp_rdy) begin
      @(negedge clk);
      assert (cacheresp_val && cacheresp_type == held_type && cacheresp_data == held_data
              && cacheresp_hit == held_hit)
        else report_failure("response changed while cacheresp_rdy was low");
      cacheresp_rdy = ($urandom_range(2) != 0);
    end
    @(negedge clk);
    cacheresp_rdy = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    int cycle_count;
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count > max_cycles)
        report_failure($sformatf("timeout: run did not finish within %0d cycles", max_cycles));
    end
  end

  // Memory side, sampled after the falling-edge drives settle
  initial begin
    logic                      held;
    cache_types_pkg::mem_op_e  held_type;
    cache_cfg_pkg::addr_t      held_addr;
    cache_cfg_pkg::line_t      held_data;
    held    = 1'b0;
    wb_done = 0;
    forever begin
      @(negedge clk);
      #1;
      if (held) begin
        assert (memreq_val && memreq_type == held_type && memreq_addr == held_addr
                && memreq_data == held_data)
          else report_failure("memory request changed while memreq_rdy was low");
      end
      if (memreq_val && memreq_rdy && memreq_type == cache_types_pkg::mem_write) begin
        assert (wb_done < wb_due) else report_failure("write-back of a line that was not dirty");
        assert (memreq_addr == wb_addr)
          else report_mismatch("write-back address", wb_addr, memreq_addr);
        for (int w = 0; w < 4; w++) begin
          assert (memreq_data[w*32 +: 32] == expected_word(memreq_addr + 4 * w))
            else report_mismatch("write-back data", expected_word(memreq_addr + 4 * w),
                                 memreq_data[w*32 +: 32]);
        end
        wb_done++;
      end
      held      = memreq_val && !memreq_rdy;
      held_type = memreq_type;
      held_addr = memreq_addr;
      held_data = memreq_data;
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------

  initial begin
    cache_cfg_pkg::addr_t addr;
    void'($urandom(43405));
    reset         = 1'b1;
    cachereq_val  = 1'b0;
    cachereq_type = 2'd0;
    cachereq_addr = '0;
    cachereq_data = '0;
    cacheresp_rdy = 1'b0;
    model_valid   = '0;
    model_dirty   = '0;
    model_lru     = '0;
    wb_due        = 0;
    wb_addr       = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    assert (cachereq_rdy && !cacheresp_val && !memreq_val && !memresp_rdy)
      else report_failure("handshake outputs are not in their reset state");
    // Every line installed word by word through init
    for (int i = 0; i < num_lines; i++) begin
      for (int w = 0; w < 4; w++) begin
        addr = line_base(i) + 4 * w;
        run_request(cache_types_pkg::op_init, addr, default_word(addr));
      end
    end
    for (int n = num_lines * 4; n < num_requests; n++) begin
      addr = line_base(int'($urandom_range(num_lines - 1))) + 4 * $urandom_range(3);
      run_request($urandom_range(1) ? cache_types_pkg::op_write : cache_types_pkg::op_read,
                  addr, $urandom);
    end
    $display("all tests passed");
    $finish;
  end

endmodule

/* blocking_cache.f */
design/cache_cfg_pkg.sv
design/cache_types_pkg.sv
design/cache_ifc.sv
design/cache_req_decode.sv
design/cache_ctrl_fsm.sv
design/cache_way_arrays.sv
design/cache_resp_unit.sv
design/blocking_cache.sv
tests/tb_mem_model.sv
tests/tb_blocking_cache.sv

/* Makefile */
# Verilator build and run of the blocking cache testbench

TOP := tb_blocking_cache

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f blocking_cache.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
